// File: Makefile
SRCS := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_cache: sim.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_cache -f sim.f

run: obj_dir/Vtb_cache
	@out=$$(./obj_dir/Vtb_cache); echo "$$out"; \
		echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// File: bench/mem_model.sv
module mem_model #(
    parameter logic [31:0] fill_pattern = 32'h0
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             rd_req,
    input  bus_pkg::rd_req_t rd,
    output logic             rd_rdy,
    output logic             ret_valid,
    output bus_pkg::ret_t    ret,
    input  logic             wr_req,
    input  bus_pkg::wr_req_t wr,
    output logic             wr_rdy
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [logic [31:0]];   // only written words are stored
    logic [31:0] rnd;
    logic [31:0] line_addr;
    logic        busy;                 // a line read is being returned
    int          beat;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] load_word(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ fill_pattern;   // untouched words follow their address
    endfunction

    initial begin
        rnd       = 32'd13;
        busy      = 1'b0;
        beat      = 0;
        line_addr = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret       = '0;
        forever begin
            @(posedge clk);
            if (!resetn) begin
                busy = 1'b0;
                beat = 0;
            end else begin
                if (ret_valid) begin
                    beat++;
                    if (beat == 4) busy = 1'b0;
                end
                if (rd_req && rd_rdy) begin
                    busy      = 1'b1;
                    beat      = 0;
                    line_addr = rd.addr;
                end
                if (wr_req) begin
                    for (int i = 0; i < 4; i++) begin
                        mem[wr.addr + 32'(4 * i)] = wr.data[i*32 +: 32];
                    end
                end
            end
            #1;
            rnd       = next_rand(rnd);
            rd_rdy    = resetn && !busy && (rnd[1:0] != 2'b00);
            wr_rdy    = resetn && (rnd[3:2] != 2'b00);
            ret_valid = busy && (rnd[5:4] != 2'b00);   // gaps inside the burst
            ret.last  = (beat == 3);
            ret.data  = load_word(line_addr + 32'(4 * beat));
        end
    end

endmodule

// File: bench/tb_cache.sv
module tb_cache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] fill_pattern = 32'h3c5a_a5c3;
    localparam int          wait_limit   = 300;

    logic                clk;
    logic                resetn;
    logic                valid;
    cache_pkg::cpu_req_t req;
    logic                addr_ok, data_ok, rd_req, rd_rdy, ret_valid, wr_req, wr_rdy;
    logic [31:0]         rdata;
    bus_pkg::rd_req_t    rd;
    bus_pkg::wr_req_t    wr;
    bus_pkg::ret_t       ret;

    logic [31:0]  shadow [logic [31:0]];
    logic [31:0]  exp_rdata;
    logic [127:0] wb_line;    // shadow copy of the line under wr.addr
    logic [31:0]  wb_addr;
    logic [31:0]  pending_line;   // line of the last accepted request
    logic         wb_watch, expect_hit, outstanding;
    logic         timed_out;
    int           errors;

    cache_top UUT (.*);

    mem_model #(.fill_pattern(fill_pattern)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a)) return shadow[a];
        return a ^ fill_pattern;
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] set,
                                              input logic [1:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout waiting for %s", what);
    endtask

    // one request from valid to data_ok
    task automatic access(input cache_pkg::cpu_op_t op, input logic [31:0] a,
                          input logic [3:0] strb, input logic [31:0] d, input logic hit);
        int          n;
        logic [31:0] w;
        if (timed_out) return;   // the run is already lost
        req.op     = op;
        req.index  = a[11:4];
        req.tag    = a[31:12];
        req.offset = a[3:0];
        req.wstrb  = strb;
        req.wdata  = d;
        expect_hit = hit;
        exp_rdata  = shadow_word(a);
        valid      = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!addr_ok && n < wait_limit);
        if (!addr_ok) begin
            report_timeout("addr_ok");
            #1 valid = 1'b0;
            return;
        end
        outstanding  = 1'b1;
        pending_line = {a[31:4], 4'b0000};
        if (op == cache_pkg::op_write) begin
            w = shadow_word(a);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) w[b*8 +: 8] = d[b*8 +: 8];
            end
            shadow[a] = w;
        end
        #1 valid = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!data_ok && n < wait_limit);
        if (!data_ok) begin
            report_timeout("data_ok");
        end
        outstanding = 1'b0;
        #1;
    endtask

    // wr.addr holds for a cycle in miss before wr_req, so last cycle's line is the one sent
    always @(posedge clk) begin
        if (!$isunknown(wr.addr)) begin
            wb_line <= {shadow_word(wr.addr + 12), shadow_word(wr.addr + 8),
                        shadow_word(wr.addr + 4), shadow_word(wr.addr)};
        end
    end

    assert property (@(posedge clk) $rose(resetn) |-> addr_ok && !rd_req && !wr_req && !data_ok)
        else flag_mismatch("outputs not idle after reset");
    assert property (@(posedge clk) disable iff (!resetn) data_ok |-> outstanding)
        else flag_mismatch("data_ok without a pending request");
    assert property (@(posedge clk) disable iff (!resetn)
                     data_ok && req.op == cache_pkg::op_read |-> rdata == exp_rdata)
        else flag_mismatch("read data differs from shadow memory");
    assert property (@(posedge clk) disable iff (!resetn)
                     valid && addr_ok && req.op == cache_pkg::op_read && expect_hit |=> data_ok)
        else flag_mismatch("read hit not answered in one cycle");
    assert property (@(posedge clk) disable iff (!resetn)
                     wr_req |-> wr.data == wb_line && wr.strb == 4'hf &&
                                wr.rtype == bus_pkg::req_line)
        else flag_mismatch("written back line differs from shadow memory");
    assert property (@(posedge clk) disable iff (!resetn) wr_req && wb_watch |-> wr.addr == wb_addr)
        else flag_mismatch("wrong victim line written back");
    assert property (@(posedge clk) disable iff (!resetn)
                     rd_req |-> rd.addr == pending_line && rd.rtype == bus_pkg::req_line)
        else flag_mismatch("line read request for the wrong line");
    assert property (@(posedge clk) disable iff (!resetn) rd_req && !rd_rdy |=> rd_req && $stable(rd))
        else flag_mismatch("line read request changed while stalled");
    assert property (@(posedge clk) disable iff (!resetn)
                     rd_req || wr_req || (outstanding && !data_ok) |-> !addr_ok)
        else flag_mismatch("addr_ok high during a miss");

    initial begin
        logic [31:0] rnd;
        resetn = 1'b0;
        valid = 1'b0;
        req = '0;
        errors = 0;
        timed_out = 1'b0;
        wb_watch = 1'b0;
        wb_addr = '0;
        pending_line = '0;
        expect_hit = 1'b0;
        outstanding = 1'b0;
        rnd = 32'd13;
        repeat (3) @(posedge clk);
        #1 resetn = 1'b1;

        // misses, hits and a store then same-word read in set 3
        access(cache_pkg::op_read, make_addr(20'h1, 8'd3, 2'd2), 4'h0, 32'h0, 1'b0);
        access(cache_pkg::op_read, make_addr(20'h1, 8'd3, 2'd0), 4'h0, 32'h0, 1'b1);
        access(cache_pkg::op_write, make_addr(20'h1, 8'd3, 2'd1), 4'b0110, 32'h1122_3344, 1'b0);
        access(cache_pkg::op_read, make_addr(20'h1, 8'd3, 2'd1), 4'h0, 32'h0, 1'b1);
        access(cache_pkg::op_read, make_addr(20'h2, 8'd3, 2'd3), 4'h0, 32'h0, 1'b0);
        access(cache_pkg::op_read, make_addr(20'h1, 8'd3, 2'd2), 4'h0, 32'h0, 1'b1);
        access(cache_pkg::op_read, make_addr(20'h2, 8'd3, 2'd3), 4'h0, 32'h0, 1'b1);

        // dirty line of tag 5 in set 7 is evicted by the third tag
        access(cache_pkg::op_write, make_addr(20'h5, 8'd7, 2'd0), 4'b1001, 32'haabb_ccdd, 1'b0);
        access(cache_pkg::op_write, make_addr(20'h5, 8'd7, 2'd3), 4'hf, 32'h0bad_cafe, 1'b0);
        access(cache_pkg::op_read, make_addr(20'h6, 8'd7, 2'd1), 4'h0, 32'h0, 1'b0);
        wb_addr  = make_addr(20'h5, 8'd7, 2'd0);
        wb_watch = 1'b1;
        access(cache_pkg::op_read, make_addr(20'h9, 8'd7, 2'd2), 4'h0, 32'h0, 1'b0);
        wb_watch = 1'b0;
        access(cache_pkg::op_read, make_addr(20'h5, 8'd7, 2'd0), 4'h0, 32'h0, 1'b0);

        // random mix over two sets and three tags each
        for (int k = 0; k < 60; k++) begin
            rnd = next_rand(rnd);
            access(rnd[5] ? cache_pkg::op_write : cache_pkg::op_read,
                   make_addr(20'(rnd[1:0] % 3 + 11), 8'd20 + 8'(rnd[2]), rnd[4:3]),
                   rnd[9:6], next_rand(rnd), 1'b0);
        end

        repeat (5) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hw/bus_pkg.sv
package bus_pkg;

    // a whole cache line, four words
    localparam int line_w = 128;

    // only line transfers are left on this bus
    typedef enum logic [2:0] {
        req_line = 3'd4
    } bus_type_t;

    typedef struct packed {
        bus_type_t   rtype;
        logic [31:0] addr;   // line aligned
    } rd_req_t;

    // write back of a full line
    typedef struct packed {
        bus_type_t         rtype;
        logic [31:0]       addr;
        logic [3:0]        strb;
        logic [line_w-1:0] data;   // word 3 in the top bits
    } wr_req_t;

    // one returned word of a line read
    typedef struct packed {
        logic        last;
        logic [31:0] data;
    } ret_t;

endpackage

// File: hw/cache.sv
module cache (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  valid,
    input  cache_pkg::cpu_req_t                   req,
    output logic                                  addr_ok,
    output logic                                  data_ok,
    output logic [31:0]                           rdata,
    output logic                                  rd_req,
    output bus_pkg::rd_req_t                      rd,
    input  logic                                  rd_rdy,
    input  logic                                  ret_valid,
    input  bus_pkg::ret_t                         ret,
    output logic                                  wr_req,
    output bus_pkg::wr_req_t                      wr,
    input  logic                                  wr_rdy,
    output logic [cache_pkg::index_w-1:0]         tag_addr,
    output logic [cache_pkg::n_ways-1:0]          tag_we,
    output logic [cache_pkg::tag_w:0]             tag_wdata,
    input  logic [cache_pkg::n_ways-1:0][cache_pkg::tag_w:0]        tag_rdata,
    output logic [cache_pkg::n_banks-1:0][cache_pkg::index_w-1:0]   bank_addr,
    output logic [cache_pkg::n_ways-1:0][cache_pkg::n_banks-1:0][3:0] bank_we,
    output logic [cache_pkg::n_banks-1:0][31:0]                     bank_wdata,
    input  logic [cache_pkg::n_ways-1:0][cache_pkg::n_banks-1:0][31:0] bank_rdata,
    output logic [cache_pkg::index_w-1:0]         ws_index,
    output logic                                  ws_hit,
    output logic                                  ws_hit_way,
    output logic                                  refill_done,
    output cache_pkg::cpu_op_t                    refill_op,
    output logic                                  store_commit,
    output logic                                  commit_way,
    output logic [cache_pkg::index_w-1:0]         commit_index,
    input  logic                                  victim_way,
    input  logic                                  victim_dirty
);

    // pending store hit, written to its bank one cycle after lookup
    typedef struct packed {
        logic                          way;
        logic [cache_pkg::index_w-1:0] index;
        logic [cache_pkg::bank_w-1:0]  bank;
        logic [3:0]                    wstrb;
        logic [31:0]                   wdata;
    } wrbuf_t;

    cache_pkg::main_state_t  state, state_nxt;
    cache_pkg::wrbuf_state_t wr_state;
    cache_pkg::cpu_req_t     req_r;   // request buffer
    wrbuf_t                  wrbuf;

    logic [cache_pkg::n_ways-1:0]  way_hit;
    logic                          cache_hit;
    logic                          hit_way;
    logic                          hit_write;
    logic                          conflict;
    logic                          accept;
    logic                          miss_settled;
    logic                          victim_valid;
    logic [cache_pkg::tag_w-1:0]   victim_tag;
    logic [cache_pkg::bank_w-1:0]  req_bank;
    logic [cache_pkg::bank_w-1:0]  ret_cnt;
    logic [cache_pkg::index_w-1:0] rd_index;
    logic [31:0]                   hit_word;
    logic [31:0]                   merged_word;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= req;
        end
    end

    assign req_bank = req_r.offset[cache_pkg::offset_w-1 -: cache_pkg::bank_w];

    // hit logic on the tags read in the accepting cycle
    always_comb begin
        for (int w = 0; w < cache_pkg::n_ways; w++) begin
            way_hit[w] = tag_rdata[w][0] && (tag_rdata[w][cache_pkg::tag_w:1] == req_r.tag);
        end
    end

    assign cache_hit = |way_hit;
    assign hit_way   = way_hit[1];
    assign hit_word  = bank_rdata[hit_way][req_bank];
    assign hit_write = (state == cache_pkg::lookup) && cache_hit && (req_r.op == cache_pkg::op_write);

    assign victim_valid = tag_rdata[victim_way][0];
    assign victim_tag   = tag_rdata[victim_way][cache_pkg::tag_w:1];

    // a read must not see a bank that the write buffer is about to change
    assign conflict = (req.op == cache_pkg::op_read) &&
        (((wr_state == cache_pkg::wr_write) &&
          (req.offset[cache_pkg::offset_w-1 -: cache_pkg::bank_w] == wrbuf.bank)) ||
         ((state == cache_pkg::lookup) && (req_r.op == cache_pkg::op_write) &&
          (req.tag == req_r.tag) && (req.index == req_r.index) &&
          (req.offset[cache_pkg::offset_w-1 -: cache_pkg::bank_w] == req_bank)));

    assign addr_ok = !conflict &&
        ((state == cache_pkg::idle) || ((state == cache_pkg::lookup) && cache_hit));
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= cache_pkg::idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::idle: begin
                if (accept) state_nxt = cache_pkg::lookup;
            end
            cache_pkg::lookup: begin
                if (cache_hit) begin
                    state_nxt = accept ? cache_pkg::lookup : cache_pkg::idle;
                end else if (victim_valid && victim_dirty) begin
                    state_nxt = cache_pkg::miss;
                end else begin
                    state_nxt = cache_pkg::replace;   // clean victim is just dropped
                end
            end
            cache_pkg::miss: begin
                if (wr_req) state_nxt = cache_pkg::replace;
            end
            cache_pkg::replace: begin
                if (rd_rdy) state_nxt = cache_pkg::refill;
            end
            cache_pkg::refill: begin
                if (ret_valid && ret.last) state_nxt = cache_pkg::idle;
            end
            default: state_nxt = cache_pkg::idle;
        endcase
    end

    // victim words are stable after one full cycle in miss
    always_ff @(posedge clk) begin
        if (!resetn) begin
            miss_settled <= 1'b0;
        end else begin
            miss_settled <= (state == cache_pkg::miss);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_state <= cache_pkg::wr_idle;
        end else begin
            wr_state <= hit_write ? cache_pkg::wr_write : cache_pkg::wr_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write) begin
            wrbuf <= '{way: hit_way, index: req_r.index, bank: req_bank,
                       wstrb: req_r.wstrb, wdata: req_r.wdata};
        end
    end

    // refill word counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ret_cnt <= '0;
        end else if ((state == cache_pkg::refill) && ret_valid) begin
            ret_cnt <= ret.last ? '0 : ret_cnt + 1'b1;
        end
    end

    // store miss bytes over the returned word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[b*8 +: 8] = req_r.wstrb[b] ? req_r.wdata[b*8 +: 8] : ret.data[b*8 +: 8];
        end
    end

    assign rd_index  = accept ? req.index : req_r.index;
    assign tag_addr  = rd_index;
    assign tag_wdata = {req_r.tag, 1'b1};

    assign refill_done = (state == cache_pkg::refill) && ret_valid && ret.last;
    assign refill_op   = req_r.op;

    always_comb begin
        for (int w = 0; w < cache_pkg::n_ways; w++) begin
            tag_we[w] = refill_done && (victim_way == w);
        end
    end

    always_comb begin
        for (int i = 0; i < cache_pkg::n_banks; i++) begin
            bank_addr[i]  = rd_index;
            bank_wdata[i] = ret.data;
            if ((req_r.op == cache_pkg::op_write) && (req_bank == i)) begin
                bank_wdata[i] = merged_word;
            end
            if ((wr_state == cache_pkg::wr_write) && (wrbuf.bank == i)) begin
                bank_addr[i]  = wrbuf.index;   // write buffer owns this bank
                bank_wdata[i] = wrbuf.wdata;
            end
            for (int w = 0; w < cache_pkg::n_ways; w++) begin
                bank_we[w][i] = '0;
                if ((wr_state == cache_pkg::wr_write) && (wrbuf.bank == i) && (wrbuf.way == w)) begin
                    bank_we[w][i] = wrbuf.wstrb;
                end else if ((state == cache_pkg::refill) && ret_valid && (ret_cnt == i) &&
                             (victim_way == w)) begin
                    bank_we[w][i] = 4'hf;
                end
            end
        end
    end

    assign ws_index     = req_r.index;
    assign ws_hit       = (state == cache_pkg::lookup) && cache_hit;
    assign ws_hit_way   = hit_way;
    assign store_commit = (wr_state == cache_pkg::wr_write);
    assign commit_way   = wrbuf.way;
    assign commit_index = wrbuf.index;

    // stores finish in lookup, read misses on their own returned word
    assign data_ok = ((state == cache_pkg::lookup) &&
                      (cache_hit || (req_r.op == cache_pkg::op_write))) ||
                     ((state == cache_pkg::refill) && ret_valid &&
                      (req_r.op == cache_pkg::op_read) && (ret_cnt == req_bank));
    assign rdata   = (state == cache_pkg::refill) ? ret.data : hit_word;

    assign rd_req   = (state == cache_pkg::replace);
    assign rd.rtype = bus_pkg::req_line;
    assign rd.addr  = {req_r.tag, req_r.index, {cache_pkg::offset_w{1'b0}}};

    assign wr_req   = (state == cache_pkg::miss) && miss_settled && wr_rdy;
    assign wr.rtype = bus_pkg::req_line;
    assign wr.addr  = {victim_tag, req_r.index, {cache_pkg::offset_w{1'b0}}};
    assign wr.strb  = 4'hf;
    assign wr.data  = bank_rdata[victim_way];   // bank 3 ends up in the top word

    assert property (@(posedge clk) disable iff (!resetn)
                     rd_req && !rd_rdy |=> rd_req && $stable(rd))
        else $error("rd_req dropped or changed before rd_rdy");

    assert property (@(posedge clk) disable iff (!resetn) wr_req |-> wr_rdy)
        else $error("wr_req without wr_rdy");

    assert property (@(posedge clk) disable iff (!resetn)
                     data_ok |-> state != cache_pkg::idle)
        else $error("data_ok in idle");

endmodule

// File: hw/cache_pkg.sv
package cache_pkg;

    // address split is tag | index | offset
    localparam int tag_w    = 20;
    localparam int index_w  = 8;
    localparam int offset_w = 4;

    localparam int n_ways  = 2;
    localparam int n_banks = 4;   // 32-bit words per line
    localparam int n_sets  = 256;

    // word select inside a line, top bits of the offset
    localparam int bank_w = $clog2(n_banks);

    // controller main FSM
    typedef enum logic [2:0] {
        idle,
        lookup,   // tag compare on the buffered request
        miss,     // dirty victim waits for wr_rdy
        replace,  // line read request waits for rd_rdy
        refill    // returned words go into the banks
    } main_state_t;

    // store hits are committed one cycle after lookup
    typedef enum logic {
        wr_idle,
        wr_write
    } wrbuf_state_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cpu_op_t;

    // one CPU request, 69 bits
    typedef struct packed {
        cpu_op_t             op;
        logic [index_w-1:0]  index;   // addr[11:4]
        logic [tag_w-1:0]    tag;     // physical tag, same cycle as index
        logic [offset_w-1:0] offset;  // addr[3:0]
        logic [3:0]          wstrb;   // byte enables for stores
        logic [31:0]         wdata;
    } cpu_req_t;

endpackage

// File: hw/cache_top.sv
module cache_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  cache_pkg::cpu_req_t req,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rdata,
    output logic                rd_req,
    output bus_pkg::rd_req_t    rd,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  bus_pkg::ret_t       ret,
    output logic                wr_req,
    output bus_pkg::wr_req_t    wr,
    input  logic                wr_rdy
);

    logic [cache_pkg::index_w-1:0]                            tag_addr;
    logic [cache_pkg::n_ways-1:0]                             tag_we;
    logic [cache_pkg::tag_w:0]                                tag_wdata;
    logic [cache_pkg::n_ways-1:0][cache_pkg::tag_w:0]         tag_rdata;
    logic [cache_pkg::n_banks-1:0][cache_pkg::index_w-1:0]    bank_addr;
    logic [cache_pkg::n_ways-1:0][cache_pkg::n_banks-1:0][3:0] bank_we;
    logic [cache_pkg::n_banks-1:0][31:0]                      bank_wdata;
    logic [cache_pkg::n_ways-1:0][cache_pkg::n_banks-1:0][31:0] bank_rdata;

    logic [cache_pkg::index_w-1:0] ws_index, commit_index;
    logic                          ws_hit, ws_hit_way, refill_done, store_commit, commit_way;
    logic                          victim_way, victim_dirty;
    cache_pkg::cpu_op_t            refill_op;

    cache u_cache (.*);

    way_state u_way_state (
        .clk, .resetn,
        .index(ws_index), .hit(ws_hit), .hit_way(ws_hit_way),
        .refill_done, .refill_op, .store_commit, .commit_way, .commit_index,
        .victim_way, .victim_dirty
    );

    // one tag RAM and four word banks per way
    for (genvar w = 0; w < cache_pkg::n_ways; w++) begin : g_way
        tag_ram u_tag (
            .clk, .resetn, .we(tag_we[w]), .addr(tag_addr),
            .wdata(tag_wdata), .rdata(tag_rdata[w])
        );
        for (genvar i = 0; i < cache_pkg::n_banks; i++) begin : g_bank
            data_bank_ram u_bank (
                .clk, .we(bank_we[w][i]), .addr(bank_addr[i]),
                .wdata(bank_wdata[i]), .rdata(bank_rdata[w][i])
            );
        end
    end

endmodule

// File: hw/data_bank_ram.sv
module data_bank_ram (
    input  logic                          clk,
    input  logic [3:0]                    we,      // one bit per byte lane
    input  logic [cache_pkg::index_w-1:0] addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata
);

    logic [31:0] mem [cache_pkg::n_sets];

    // old word comes out when reading and writing the same set
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

endmodule

// File: hw/tag_ram.sv
module tag_ram (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          we,
    input  logic [cache_pkg::index_w-1:0] addr,
    input  logic [cache_pkg::tag_w:0]     wdata,   // {tag, valid}
    output logic [cache_pkg::tag_w:0]     rdata
);

    logic [cache_pkg::tag_w-1:0]  tag_mem [cache_pkg::n_sets];
    logic [cache_pkg::n_sets-1:0] valid_bits;   // flops, cleared in one cycle

    always_ff @(posedge clk) begin
        rdata <= {tag_mem[addr], valid_bits[addr]};   // read first
        if (we) begin
            tag_mem[addr] <= wdata[cache_pkg::tag_w:1];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (we) begin
            valid_bits[addr] <= wdata[0];
        end
    end

    // a refill must always land on a known set
    assert property (@(posedge clk) we |-> !$isunknown(addr))
        else $error("tag_ram write with unknown address");

endmodule

// File: hw/way_state.sv
module way_state (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [cache_pkg::index_w-1:0] index,          // set of the request in lookup
    input  logic                          hit,
    input  logic                          hit_way,
    input  logic                          refill_done,
    input  cache_pkg::cpu_op_t            refill_op,
    input  logic                          store_commit,
    input  logic                          commit_way,
    input  logic [cache_pkg::index_w-1:0] commit_index,
    output logic                          victim_way,
    output logic                          victim_dirty
);

    logic [cache_pkg::n_ways-1:0][cache_pkg::n_sets-1:0] dirty;
    logic [cache_pkg::n_sets-1:0]                        repl;   // way to evict next

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty <= '0;
            repl  <= '0;
        end else begin
            if (hit) begin
                repl[index] <= ~hit_way;   // keep the way just used
            end
            if (refill_done) begin
                // a store miss leaves the new line dirty
                dirty[victim_way][index] <= (refill_op == cache_pkg::op_write);
                repl[index]              <= ~repl[index];
            end
            if (store_commit) begin
                dirty[commit_way][commit_index] <= 1'b1;
            end
        end
    end

    assign victim_way   = repl[index];
    assign victim_dirty = dirty[victim_way][index];

    // a store hit is committed right after its lookup, never during a refill
    assert property (@(posedge clk) disable iff (!resetn) !(refill_done && store_commit))
        else $error("refill and store commit in the same cycle");

endmodule

// File: sim.f
hw/cache_pkg.sv
hw/bus_pkg.sv
hw/tag_ram.sv
hw/data_bank_ram.sv
hw/way_state.sv
hw/cache.sv
hw/cache_top.sv
bench/mem_model.sv
bench/tb_cache.sv
